/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int XLEN         = 32;        // data and address width
  localparam int ICACHE_LINES = 16;        // one word per line
  localparam int BHT_ENTRIES  = 64;        // two-bit counters
  localparam int FOQ_DEPTH    = 8;         // fetch queue slots
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // derived widths
  localparam int ICACHE_IDX_W = $clog2(ICACHE_LINES);
  localparam int ICACHE_TAG_W = XLEN - ICACHE_IDX_W - 2;  // above index and byte offset
  localparam int BHT_IDX_W    = $clog2(BHT_ENTRIES);
  localparam int FOQ_PTR_W    = $clog2(FOQ_DEPTH);
  localparam int FOQ_CNT_W    = FOQ_PTR_W + 1;            // must hold FOQ_DEPTH itself

  // decoded operation class
  typedef enum logic [3:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,   // conditional branches only
    op_load,
    op_store,
    op_op_imm,
    op_op,
    op_illegal
  } op_e;

  // queue entry payload
  typedef struct packed {
    op_e             op;
    logic            branch;   // conditional branch
    logic            ls;       // load or store
    logic            use_imm;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;      // sign extended
    logic            jalr;
  } decoded_t;

endpackage

`default_nettype wire

/* fetch_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one decoded instruction on its way from fetch into the queue
interface fetch_if;
  import fetch_pkg::*;

  decoded_t        dec;
  logic [XLEN-1:0] pc;     // address of dec
  logic            push;   // one cycle strobe, one instruction

  // fetch unit side
  modport src (output dec, output pc, output push);

  // fetch queue side
  modport sink (input dec, input pc, input push);

  // predictor looks at what is being pushed
  modport monitor (input dec, input pc, input push);

endinterface

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
  input  logic [31:0]         inst,
  output fetch_pkg::decoded_t dec
);
  import fetch_pkg::*;

  logic [XLEN-1:0] i_imm;
  logic [XLEN-1:0] s_imm;
  logic [XLEN-1:0] b_imm;
  logic [XLEN-1:0] u_imm;
  logic [XLEN-1:0] j_imm;
  logic [4:0]      f_rd;
  logic [4:0]      f_rs1;
  logic [4:0]      f_rs2;

  // register fields sit at fixed positions in every format
  assign f_rd  = inst[11:7];
  assign f_rs1 = inst[19:15];
  assign f_rs2 = inst[24:20];

  // immediates per format, all sign extended from bit 31
  assign i_imm = {{20{inst[31]}}, inst[31:20]};
  assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign u_imm = {inst[31:12], 12'b0};
  assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec    = '0;          // unused fields stay zero
    dec.op = op_illegal;  // unknown opcode, all flags low
    case (inst[6:0])
      7'b0110111: begin // lui
        dec = '{op: op_lui, branch: 1'b0, ls: 1'b0, use_imm: 1'b1, rd: f_rd,
                rs1: 5'd0, rs2: 5'd0, imm: u_imm, jalr: 1'b0};
      end
      7'b0010111: begin // auipc
        dec = '{op: op_auipc, branch: 1'b0, ls: 1'b0, use_imm: 1'b1, rd: f_rd,
                rs1: 5'd0, rs2: 5'd0, imm: u_imm, jalr: 1'b0};
      end
      7'b1101111: begin // jal, target is pc + imm
        dec = '{op: op_jal, branch: 1'b0, ls: 1'b0, use_imm: 1'b1, rd: f_rd,
                rs1: 5'd0, rs2: 5'd0, imm: j_imm, jalr: 1'b0};
      end
      7'b1100111: begin // jalr, target only known in the back end
        dec = '{op: op_jalr, branch: 1'b0, ls: 1'b0, use_imm: 1'b1, rd: f_rd,
                rs1: f_rs1, rs2: 5'd0, imm: i_imm, jalr: 1'b1};
      end
      7'b1100011: begin // beq .. bgeu, compares two registers
        dec = '{op: op_branch, branch: 1'b1, ls: 1'b0, use_imm: 1'b0, rd: 5'd0,
                rs1: f_rs1, rs2: f_rs2, imm: b_imm, jalr: 1'b0};
      end
      7'b0000011: begin // loads
        dec = '{op: op_load, branch: 1'b0, ls: 1'b1, use_imm: 1'b1, rd: f_rd,
                rs1: f_rs1, rs2: 5'd0, imm: i_imm, jalr: 1'b0};
      end
      7'b0100011: begin // stores, no rd
        dec = '{op: op_store, branch: 1'b0, ls: 1'b1, use_imm: 1'b1, rd: 5'd0,
                rs1: f_rs1, rs2: f_rs2, imm: s_imm, jalr: 1'b0};
      end
      7'b0010011: begin // alu with immediate
        dec = '{op: op_op_imm, branch: 1'b0, ls: 1'b0, use_imm: 1'b1, rd: f_rd,
                rs1: f_rs1, rs2: 5'd0, imm: i_imm, jalr: 1'b0};
      end
      7'b0110011: begin // register-register alu
        dec = '{op: op_op, branch: 1'b0, ls: 1'b0, use_imm: 1'b0, rd: f_rd,
                rs1: f_rs1, rs2: f_rs2, imm: '0, jalr: 1'b0};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* inst_processor.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_processor (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         rdy_in,
  // icache link
  output logic [fetch_pkg::XLEN-1:0]   fetch_addr,
  input  logic                         inst_available,
  input  logic [31:0]                  inst,
  // predictor answer
  input  logic                         branch,
  input  logic [fetch_pkg::XLEN-1:0]   branch_addr,
  // back end redirects
  input  logic                         predict_fail,
  input  logic [fetch_pkg::XLEN-1:0]   fail_addr,
  input  logic                         jalr_done,
  // queue back-pressure
  input  logic                         foq_full,
  fetch_if.src                         dq
);
  import fetch_pkg::*;

  logic [XLEN-1:0] pc;
  logic            cease;         // waiting on a jalr target
  logic            decode_valid;
  logic            push;
  logic            redirect;
  logic [XLEN-1:0] next_pc;
  decoded_t        dec;

  inst_decoder decoder_i (
    .inst (inst),
    .dec  (dec)
  );

  assign fetch_addr   = pc;
  assign redirect     = predict_fail | jalr_done;
  assign decode_valid = inst_available & ~cease & ~foq_full;
  assign push         = decode_valid & rdy_in;

  assign dq.dec  = dec;
  assign dq.pc   = pc;
  assign dq.push = push;

  // next pc, highest priority first
  always_comb begin
    if (redirect) begin
      next_pc = fail_addr;              // mispredict or jalr target
    end else if (branch) begin
      next_pc = branch_addr;            // predicted taken
    end else if (dec.op == op_jal) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc + XLEN'(4);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc    <= RESET_PC;
      cease <= 1'b0;
    end else if (rdy_in) begin
      if (redirect) begin               // wins over stall and full queue
        pc    <= next_pc;
        cease <= 1'b0;
      end else if (push) begin
        pc    <= next_pc;
        cease <= dec.jalr;              // stop behind a jalr
      end
    end
  end

endmodule

`default_nettype wire

/* icache.sv */
`timescale 1ns/1ns
`default_nettype none

module icache (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       rdy_in,
  input  logic [fetch_pkg::XLEN-1:0] fetch_addr,
  output logic                       inst_available,
  output logic [fetch_pkg::XLEN-1:0] inst,
  // refill from memory
  output logic                       mem_req,
  output logic [fetch_pkg::XLEN-1:0] mem_addr,
  input  logic                       mem_valid,
  input  logic [fetch_pkg::XLEN-1:0] mem_data
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,   // mem_req held here
    st_fill       // one cycle turnaround after the write
  } cache_state_e;

  cache_state_e            state;
  logic [ICACHE_LINES-1:0] valid;
  logic [ICACHE_TAG_W-1:0] tags [ICACHE_LINES];
  logic [XLEN-1:0]         data [ICACHE_LINES];
  logic [XLEN-1:0]         miss_addr;
  logic [ICACHE_IDX_W-1:0] idx;
  logic [ICACHE_IDX_W-1:0] fill_idx;
  logic                    hit;

  assign idx      = fetch_addr[ICACHE_IDX_W+1:2];   // word index
  assign fill_idx = miss_addr[ICACHE_IDX_W+1:2];
  assign hit      = valid[idx] && (tags[idx] == fetch_addr[XLEN-1:ICACHE_IDX_W+2]);

  assign inst_available = hit;     // same cycle as fetch_addr
  assign inst           = data[idx];
  assign mem_req        = (state == st_request);
  assign mem_addr       = {miss_addr[XLEN-1:2], 2'b00};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= st_idle;
      valid     <= '0;
      miss_addr <= RESET_PC;
    end else begin
      case (state)
        st_idle: if (rdy_in && !hit) begin
          miss_addr <= fetch_addr;     // request goes out next cycle
          state     <= st_request;
        end
        st_request: if (mem_valid) begin // response is never dropped, even when paused
          valid[fill_idx] <= 1'b1;
          state           <= st_fill;
        end
        st_fill: if (rdy_in) state <= st_idle;  // a moved pc misses again from idle
        default: state <= st_idle;
      endcase
    end
  end

  // tag and data written with the response
  always_ff @(posedge clk_in) begin
    if (state == st_request && mem_valid) begin
      tags[fill_idx] <= miss_addr[XLEN-1:ICACHE_IDX_W+2];
      data[fill_idx] <= mem_data;
    end
  end

endmodule

`default_nettype wire

/* branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_predictor (
  input  logic                       clk_in,
  input  logic                       rst_in,
  fetch_if.monitor                   dq,
  output logic                       branch,
  output logic [fetch_pkg::XLEN-1:0] branch_addr,
  // training from the back end
  input  logic                       upd_valid,
  input  logic [fetch_pkg::XLEN-1:0] upd_pc,
  input  logic                       upd_taken
);
  import fetch_pkg::*;

  logic [1:0]           bht [BHT_ENTRIES];  // 00 strong nt .. 11 strong taken
  logic [BHT_IDX_W-1:0] rd_idx;
  logic [BHT_IDX_W-1:0] upd_idx;
  logic [1:0]           upd_ctr;

  assign rd_idx  = dq.pc[BHT_IDX_W+1:2];
  assign upd_idx = upd_pc[BHT_IDX_W+1:2];
  assign upd_ctr = bht[upd_idx];

  // only a pushed conditional branch with a taken counter redirects fetch
  assign branch      = dq.push && (dq.dec.op == op_branch) && bht[rd_idx][1];
  assign branch_addr = dq.pc + dq.dec.imm;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        bht[i] <= 2'b01;        // weakly not taken
      end
    end else if (upd_valid) begin
      if (upd_taken) begin
        if (upd_ctr != 2'b11) begin
          bht[upd_idx] <= upd_ctr + 2'd1;
        end
      end else if (upd_ctr != 2'b00) begin
        bht[upd_idx] <= upd_ctr - 2'd1;   // saturate at zero
      end
    end
  end

endmodule

`default_nettype wire

/* fetch_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_queue (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       rdy_in,
  input  logic                       flush,
  fetch_if.sink                      dq,
  output logic                       foq_full,
  // dispatch side
  input  logic                       deq,
  output logic                       out_valid,
  output logic [fetch_pkg::XLEN-1:0] out_pc,
  output fetch_pkg::decoded_t        out_dec
);
  import fetch_pkg::*;

  decoded_t             q_dec [FOQ_DEPTH];
  logic [XLEN-1:0]      q_pc  [FOQ_DEPTH];
  logic [FOQ_PTR_W-1:0] head;
  logic [FOQ_PTR_W-1:0] tail;
  logic [FOQ_CNT_W-1:0] count;
  logic                 pop;

  assign foq_full  = (count == FOQ_CNT_W'(FOQ_DEPTH));
  assign out_valid = (count != '0);
  assign out_pc    = q_pc[head];
  assign out_dec   = q_dec[head];
  assign pop       = deq && out_valid && rdy_in;   // deq on empty ignored

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (rdy_in) begin
      if (flush) begin            // drops a same-cycle push too
        head  <= '0;
        tail  <= '0;
        count <= '0;
      end else begin
        if (dq.push) tail <= tail + 1'b1;   // pointers wrap at depth
        if (pop) head <= head + 1'b1;
        count <= count + FOQ_CNT_W'(dq.push) - FOQ_CNT_W'(pop);
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_in) begin
    if (dq.push) begin
      q_dec[tail] <= dq.dec;
      q_pc[tail]  <= dq.pc;
    end
  end

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       rdy_in,
  // instruction memory
  output logic                       mem_req,
  output logic [fetch_pkg::XLEN-1:0] mem_addr,
  input  logic                       mem_valid,
  input  logic [fetch_pkg::XLEN-1:0] mem_data,
  // back end
  input  logic                       predict_fail,
  input  logic [fetch_pkg::XLEN-1:0] fail_addr,   // jalr target when jalr_done
  input  logic                       jalr_done,
  input  logic                       upd_valid,
  input  logic [fetch_pkg::XLEN-1:0] upd_pc,
  input  logic                       upd_taken,
  // dispatch
  input  logic                       deq,
  output logic                       out_valid,
  output logic [fetch_pkg::XLEN-1:0] out_pc,
  output fetch_pkg::op_e             out_op,
  output logic                       out_branch,
  output logic                       out_ls,
  output logic                       out_use_imm,
  output logic [4:0]                 out_rd,
  output logic [4:0]                 out_rs1,
  output logic [4:0]                 out_rs2,
  output logic [fetch_pkg::XLEN-1:0] out_imm,
  output logic                       out_jalr
);
  import fetch_pkg::*;

  logic [XLEN-1:0] fetch_addr;
  logic            inst_available;
  logic [XLEN-1:0] inst;
  logic            branch;
  logic [XLEN-1:0] branch_addr;
  logic            foq_full;
  logic            flush;
  decoded_t        out_dec;

  fetch_if dq ();

  assign flush = predict_fail | jalr_done;   // any redirect empties the queue

  // head entry split into plain ports
  assign out_op      = out_dec.op;
  assign out_branch  = out_dec.branch;
  assign out_ls      = out_dec.ls;
  assign out_use_imm = out_dec.use_imm;
  assign out_rd      = out_dec.rd;
  assign out_rs1     = out_dec.rs1;
  assign out_rs2     = out_dec.rs2;
  assign out_imm     = out_dec.imm;
  assign out_jalr    = out_dec.jalr;

  icache icache_i (
    .clk_in, .rst_in, .rdy_in, .fetch_addr, .inst_available, .inst,
    .mem_req, .mem_addr, .mem_valid, .mem_data
  );

  inst_processor inst_processor_i (
    .clk_in, .rst_in, .rdy_in, .fetch_addr, .inst_available, .inst,
    .branch, .branch_addr, .predict_fail, .fail_addr, .jalr_done,
    .foq_full, .dq (dq.src)
  );

  branch_predictor branch_predictor_i (
    .clk_in, .rst_in, .dq (dq.monitor), .branch, .branch_addr,
    .upd_valid, .upd_pc, .upd_taken
  );

  fetch_queue fetch_queue_i (
    .clk_in, .rst_in, .rdy_in, .flush, .dq (dq.sink), .foq_full,
    .deq, .out_valid, .out_pc, .out_dec
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

// free running testbench clock, 4 ns period
module tb_clock (
  output logic clk_in
);

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;   // half period
  end

endmodule

`default_nettype wire

/* fetch_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_properties (
  input logic                              clk_in,
  input logic                              rst_in,
  input logic                              rdy_in,
  input logic                              mem_req,
  input logic                              mem_valid,
  input logic                              out_valid,
  input logic                              push,
  input logic                              push_jalr,   // jalr flag of the pushed entry
  input logic                              foq_full,
  input logic                              predict_fail,
  input logic                              jalr_done,
  input logic [fetch_pkg::FOQ_CNT_W-1:0]   count
);
  import fetch_pkg::*;

  int   fail_count = 0;   // read by the testbench at the end
  logic jalr_stall;       // a jalr went in, target still open

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      jalr_stall <= 1'b0;
    end else if (rdy_in && (predict_fail || jalr_done)) begin
      jalr_stall <= 1'b0;           // redirect ends the stall
    end else if (push && push_jalr) begin
      jalr_stall <= 1'b1;
    end
  end

  no_push_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
    !(push && foq_full))
    else begin
      fail_count++;
      $error("push into a full fetch queue");
    end

  count_in_range: assert property (@(posedge clk_in) disable iff (rst_in)
    count <= FOQ_CNT_W'(FOQ_DEPTH))
    else begin
      fail_count++;
      $error("fetch queue count above its depth");
    end

  // request stays up until memory answers
  mem_req_held: assert property (@(posedge clk_in) disable iff (rst_in)
    mem_req && !mem_valid |=> mem_req)
    else begin
      fail_count++;
      $error("mem_req dropped before mem_valid");
    end

  reset_quiet: assert property (@(posedge clk_in)
    rst_in |=> !mem_req && !out_valid)
    else begin
      fail_count++;
      $error("mem_req or out_valid high after reset");
    end

  redirect_empties: assert property (@(posedge clk_in) disable iff (rst_in)
    rdy_in && (predict_fail || jalr_done) |=> !out_valid)
    else begin
      fail_count++;
      $error("queue still valid after a redirect");
    end

  no_push_in_stall: assert property (@(posedge clk_in) disable iff (rst_in)
    jalr_stall |-> !push)
    else begin
      fail_count++;
      $error("push while waiting on a jalr target");
    end

endmodule

// checker sits inside the top, sees the queue count and the push strobe
bind fetch_top fetch_properties props_i (
  .clk_in, .rst_in, .rdy_in, .mem_req, .mem_valid, .out_valid,
  .push (dq.push), .push_jalr (dq.dec.jalr), .foq_full,
  .predict_fail, .jalr_done,
  .count (fetch_queue_i.count)
);

`default_nettype wire

/* fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;
  import fetch_pkg::*;

  localparam int              MAX_CYCLES  = 4000;
  localparam int              HOLD_LIMIT  = 200;     // cycles to wait for a blocked fetch
  localparam logic [XLEN-1:0] FAIL_BR_PC  = 32'h24;   // beq the back end overrules
  localparam logic [XLEN-1:0] FAIL_TARGET = 32'h44;
  localparam logic [XLEN-1:0] JALR_PC     = 32'h48;
  localparam logic [XLEN-1:0] JALR_TARGET = 32'h80;
  localparam logic [XLEN-1:0] PRED_BR_PC  = 32'h84;   // bne trained taken during the stall
  localparam logic [XLEN-1:0] END_PC      = 32'h120;

  logic            clk_in;
  logic            rst_in;
  logic            rdy_in;
  logic            mem_req;
  logic [XLEN-1:0] mem_addr;
  logic            mem_valid;
  logic [XLEN-1:0] mem_data;
  logic            predict_fail;
  logic [XLEN-1:0] fail_addr;
  logic            jalr_done;
  logic            upd_valid;
  logic [XLEN-1:0] upd_pc;
  logic            upd_taken;
  logic            deq;
  logic            out_valid;
  logic [XLEN-1:0] out_pc;
  op_e             out_op;
  logic            out_branch;
  logic            out_ls;
  logic            out_use_imm;
  logic [4:0]      out_rd;
  logic [4:0]      out_rs1;
  logic [4:0]      out_rs2;
  logic [XLEN-1:0] out_imm;
  logic            out_jalr;

  logic [31:0]     image   [256];          // 1 KiB program
  op_e             exp_op  [256];          // fields recorded while encoding
  logic [4:0]      exp_rd  [256];
  logic [4:0]      exp_rs1 [256];
  logic [4:0]      exp_rs2 [256];
  logic [XLEN-1:0] exp_imm [256];
  logic [1:0]      ctr     [BHT_ENTRIES];  // counter model, only the tb trains
  logic [31:0]     rng;
  logic [XLEN-1:0] exp_pc;                 // pc of the next head to leave
  int              errors;
  int              checks;
  int              mem_wait;
  int              stall_cnt;
  int              hold_cnt;
  logic            mem_busy;
  logic            pending_fail;
  logic            fail_done;
  logic            jalr_wait;
  logic            flush_check;
  logic            hold;                   // dispatch stalled, queue fills up
  logic            finished;

  tb_clock clock_i (.clk_in);

  fetch_top fetch_top_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    errors++;
    $display("FAIL time %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
  endtask

  task automatic report_text(input string what);
    errors++;
    $display("ERROR at time %0t: %s", $time, what);
  endtask

  task automatic put(input logic [XLEN-1:0] pc, input logic [31:0] word, input op_e op,
                     input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                     input logic [XLEN-1:0] imm);
    image[pc[9:2]]   = word;
    exp_op[pc[9:2]]  = op;
    exp_rd[pc[9:2]]  = rd;
    exp_rs1[pc[9:2]] = rs1;
    exp_rs2[pc[9:2]] = rs2;
    exp_imm[pc[9:2]] = imm;
  endtask

  // encoders, one per format used
  task automatic put_addi(input logic [XLEN-1:0] pc, input logic [4:0] rd,
                          input logic [4:0] rs1, input int imm);
    logic [31:0] v;
    v = imm;
    put(pc, {v[11:0], rs1, 3'b000, rd, 7'b0010011}, op_op_imm, rd, rs1, 5'd0, v);
  endtask

  task automatic put_add(input logic [XLEN-1:0] pc, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    put(pc, {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011}, op_op, rd, rs1, rs2, '0);
  endtask

  task automatic put_jal(input logic [XLEN-1:0] pc, input logic [4:0] rd, input int off);
    logic [31:0] v;
    v = off;
    put(pc, {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111}, op_jal, rd, 5'd0, 5'd0, v);
  endtask

  task automatic put_branch(input logic [XLEN-1:0] pc, input logic [2:0] f3,
                            input logic [4:0] rs1, input logic [4:0] rs2, input int off);
    logic [31:0] v;
    v = off;
    put(pc, {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011},
        op_branch, 5'd0, rs1, rs2, v);
  endtask

  task automatic put_jalr(input logic [XLEN-1:0] pc, input logic [4:0] rd,
                          input logic [4:0] rs1, input int off);
    logic [31:0] v;
    v = off;
    put(pc, {v[11:0], rs1, 3'b000, rd, 7'b1100111}, op_jalr, rd, rs1, 5'd0, v);
  endtask

  task automatic load_program();
    for (int w = 0; w < 256; w++) begin
      put_addi(XLEN'(w * 4), 5'(w), 5'(w), w);   // filler, differs per word
    end
    put_addi(32'h00, 5'd1, 5'd0, 1);
    put_addi(32'h04, 5'd2, 5'd1, 2);
    put_add(32'h08, 5'd3, 5'd1, 5'd2);
    put_jal(32'h0c, 5'd1, 20);                   // skips to 0x20
    put_addi(32'h20, 5'd4, 5'd3, -5);
    put_branch(FAIL_BR_PC, 3'b000, 5'd1, 5'd2, 32);
    put_add(FAIL_TARGET, 5'd5, 5'd4, 5'd3);
    put_jalr(JALR_PC, 5'd0, 5'd1, 0);
    put_addi(JALR_TARGET, 5'd6, 5'd5, -2048);    // most negative immediate
    put_branch(PRED_BR_PC, 3'b001, 5'd1, 5'd2, 60);
  endtask

  // taken update through the training port, model saturates like the table
  task automatic train(input logic [XLEN-1:0] pc);
    upd_valid = 1'b1;
    upd_pc    = pc;
    upd_taken = 1'b1;
    if (ctr[pc[BHT_IDX_W+1:2]] != 2'b11) begin
      ctr[pc[BHT_IDX_W+1:2]] = ctr[pc[BHT_IDX_W+1:2]] + 2'd1;
    end
  endtask

  task automatic check_head();
    logic [7:0] w;
    w = exp_pc[9:2];
    checks++;
    assert (out_pc == exp_pc) else report_value("out_pc", out_pc, exp_pc);
    assert (out_op == exp_op[w]) else report_value("out_op", 32'(out_op), 32'(exp_op[w]));
    assert (out_rd == exp_rd[w]) else report_value("out_rd", 32'(out_rd), 32'(exp_rd[w]));
    assert (out_rs1 == exp_rs1[w]) else report_value("out_rs1", 32'(out_rs1), 32'(exp_rs1[w]));
    assert (out_rs2 == exp_rs2[w]) else report_value("out_rs2", 32'(out_rs2), 32'(exp_rs2[w]));
    assert (out_imm == exp_imm[w]) else report_value("out_imm", out_imm, exp_imm[w]);
    assert (out_branch == (exp_op[w] == op_branch))
      else report_value("out_branch", 32'(out_branch), 32'(exp_op[w] == op_branch));
    assert (out_jalr == (exp_op[w] == op_jalr))
      else report_value("out_jalr", 32'(out_jalr), 32'(exp_op[w] == op_jalr));
    assert (!out_ls) else report_value("out_ls", 32'(out_ls), 32'd0);
    assert (out_use_imm == !(exp_op[w] inside {op_op, op_branch}))
      else report_value("out_use_imm", 32'(out_use_imm),
                        32'(!(exp_op[w] inside {op_op, op_branch})));
    case (exp_op[w])                             // where the following head must come from
      op_jal:    exp_pc = exp_pc + exp_imm[w];
      op_branch: exp_pc = ctr[exp_pc[BHT_IDX_W+1:2]][1] ? exp_pc + exp_imm[w] : exp_pc + 4;
      default:   exp_pc = exp_pc + 4;            // jalr target set at jalr_done
    endcase
  endtask

  // memory answers after 1 to 6 cycles
  task automatic step_memory();
    mem_valid = 1'b0;
    if (mem_req && !mem_busy) begin
      mem_busy = 1'b1;
      rng      = xorshift(rng);
      mem_wait = 1 + int'(rng % 6);
    end
    if (mem_busy) begin
      mem_wait--;
      if (mem_wait == 0) begin
        mem_valid = 1'b1;
        mem_data  = image[mem_addr[9:2]];
        mem_busy  = 1'b0;
      end
    end
  endtask

  task automatic step_back_end();
    predict_fail = 1'b0;
    jalr_done    = 1'b0;
    upd_valid    = 1'b0;
    deq          = 1'b0;
    rdy_in       = 1'b1;
    rng          = xorshift(rng);
    if (flush_check) begin                       // redirect edge just passed
      assert (!out_valid) else report_text("queue not empty after a redirect");
      flush_check = 1'b0;
    end
    if (pending_fail) begin
      predict_fail = 1'b1;
      fail_addr    = FAIL_TARGET;
      train(FAIL_BR_PC);
      exp_pc       = FAIL_TARGET;
      pending_fail = 1'b0;
      flush_check  = 1'b1;
    end else if (jalr_wait) begin
      assert (!out_valid) else report_text("instruction pushed behind a jalr");
      stall_cnt++;
      if (stall_cnt <= 2) begin
        train(PRED_BR_PC);                       // twice, ends strongly taken
      end else if (stall_cnt == 5) begin
        jalr_done   = 1'b1;
        fail_addr   = JALR_TARGET;
        exp_pc      = JALR_TARGET;
        jalr_wait   = 1'b0;
        flush_check = 1'b1;
      end
    end else if (hold) begin
      hold_cnt++;
      // release once a ready instruction is held back by the full queue
      if (fetch_top_i.foq_full && fetch_top_i.inst_available) begin
        hold = 1'b0;
      end else if (hold_cnt == HOLD_LIMIT) begin
        report_text("fetch queue never filled while dispatch was stalled");
        hold = 1'b0;
      end
    end else begin
      rdy_in = (rng[7:4] != 4'd0);               // rare global pause
      deq    = (rng[1:0] != 2'd0);
      if (deq && rdy_in && out_valid) begin      // head leaves on the next edge
        check_head();
        if (out_pc == FAIL_BR_PC && !fail_done) begin
          pending_fail = 1'b1;
          fail_done    = 1'b1;
        end
        if (out_jalr) begin
          jalr_wait = 1'b1;
          stall_cnt = 0;
        end
        if (out_pc == PRED_BR_PC) begin
          hold     = 1'b1;
          hold_cnt = 0;
        end
        if (exp_pc == END_PC) finished = 1'b1;
      end
    end
  endtask

  initial begin
    rst_in       = 1'b1;
    rdy_in       = 1'b1;
    mem_valid    = 1'b0;
    mem_data     = '0;
    predict_fail = 1'b0;
    fail_addr    = '0;
    jalr_done    = 1'b0;
    upd_valid    = 1'b0;
    upd_pc       = '0;
    upd_taken    = 1'b0;
    deq          = 1'b0;
    rng          = 32'h34897eb7;
    exp_pc       = RESET_PC;
    errors       = 0;
    checks       = 0;
    mem_wait     = 0;
    stall_cnt    = 0;
    hold_cnt     = 0;
    mem_busy     = 1'b0;
    pending_fail = 1'b0;
    fail_done    = 1'b0;
    jalr_wait    = 1'b0;
    flush_check  = 1'b0;
    hold         = 1'b0;
    finished     = 1'b0;
    for (int i = 0; i < BHT_ENTRIES; i++) begin
      ctr[i] = 2'b01;                            // weakly not taken
    end
    load_program();
    repeat (2) @(negedge clk_in);
    rst_in = 1'b0;
    for (int cyc = 0; cyc < MAX_CYCLES && !finished; cyc++) begin
      @(negedge clk_in);
      step_memory();
      step_back_end();
    end
    if (!finished) begin
      report_text("timeout, instruction flow never reached the end address");
    end
    $display("checked %0d instructions, %0d testbench errors, %0d assertion errors",
             checks, errors, fetch_top_i.props_i.fail_count);
    errors += fetch_top_i.props_i.fail_count;
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
fetch_pkg.sv
fetch_if.sv
inst_decoder.sv
inst_processor.sv
icache.sv
branch_predictor.sv
fetch_queue.sv
fetch_top.sv
tb_clock.sv
fetch_properties.sv
fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - fetch_pkg.sv
  - fetch_if.sv
  - inst_decoder.sv
  - inst_processor.sv
  - icache.sv
  - branch_predictor.sv
  - fetch_queue.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_clock.sv
      - fetch_properties.sv
      - fetch_tb.sv
